/* hdl/rgbw_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build constants for the RGBW dimmer
// include in any module or testbench file that needs frame, PWM or sync sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RGBW_MACROS_SVH
`define RGBW_MACROS_SVH

// bytes per SPI frame
// mode, intensity, red, green, blue, white
`define RGBW_FRAME_BYTES 6

// clk cycles per PWM counter step
// one PWM period is 255 of these ticks
`define RGBW_PWM_DIV 4

// flops in each SPI input synchroniser
// two is the minimum for metastability settling
`define RGBW_SYNC_STAGES 2

`endif

/* hdl/rgbw_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the RGBW dimmer
// committed frame, duty set, LED pins and mode codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rgbw_pkg;

    // mode byte decode
    // any value not listed here turns the LEDs off
    typedef enum logic [7:0] {
        MODE_DIRECT = 8'd0,
        MODE_SCALED = 8'd1
    } rgbw_mode_e;

    // one complete frame, first byte on the wire at the top
    // mode kept as a raw byte since off covers every other code
    typedef struct packed {
        logic [7:0] mode;
        logic [7:0] intensity;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
    } rgbw_cfg_t;

    // per-channel PWM duty
    // 0 always low, 255 always high
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] w;
    } duty_t;

    // LED drive pins
    typedef struct packed {
        logic r;
        logic g;
        logic b;
        logic w;
    } led_pins_t;

endpackage

/* hdl/spi_byte_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI mode-0 slave receiver, oversampled on clk
// delivers MSB-first bytes with a one-cycle rx_valid strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "rgbw_macros.svh"

module spi_byte_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sck,
    input  logic       cs_n,
    input  logic       mosi,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       cs_idle
);

    localparam int SYNC_N = `RGBW_SYNC_STAGES;

    // synchroniser chains, input enters at bit 0
    logic [SYNC_N-1:0] sck_sync;
    logic [SYNC_N-1:0] cs_sync;
    logic [SYNC_N-1:0] mosi_sync;
    logic              sck_prev;
    logic              sck_rise;
    // first seven bits of the byte in flight
    logic [6:0]        shift;
    logic [2:0]        bit_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck_sync  <= '0;
            // chip select idles high
            cs_sync   <= '1;
            mosi_sync <= '0;
            sck_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[SYNC_N-2:0], sck};
            cs_sync   <= {cs_sync[SYNC_N-2:0], cs_n};
            mosi_sync <= {mosi_sync[SYNC_N-2:0], mosi};
            sck_prev  <= sck_sync[SYNC_N-1];
        end
    end

    assign cs_idle = cs_sync[SYNC_N-1];

    // sample point, only inside a selected frame
    assign sck_rise = sck_sync[SYNC_N-1] & ~sck_prev & ~cs_idle;

    // bit counter and strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (cs_idle) begin
                // drops any partial byte
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid <= 1'b1;
                end
            end
        end
    end

    // data path, MSB arrives first
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            shift <= {shift[5:0], mosi_sync[SYNC_N-1]};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {shift, mosi_sync[SYNC_N-1]};
            end
        end
    end

endmodule

/* hdl/rgbw_frame_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame register block for the colour path
// stages SPI bytes by position, commits cfg only on a full frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "rgbw_macros.svh"

module rgbw_frame_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          rx_byte,
    input  logic                rx_valid,
    input  logic                cs_idle,
    output rgbw_pkg::rgbw_cfg_t cfg,
    output logic                cfg_update,
    output logic [3:0]          byte_cnt
);

    import rgbw_pkg::*;

    localparam logic [3:0] FRAME_LEN = 4'(`RGBW_FRAME_BYTES);

    // bytes of the frame in progress
    rgbw_cfg_t shadow;
    rgbw_cfg_t shadow_nxt;
    logic      take_byte;
    logic      last_byte;

    // extra bytes past the frame length fall through here
    assign take_byte = rx_valid && !cs_idle && (byte_cnt < FRAME_LEN);
    assign last_byte = take_byte && (byte_cnt == FRAME_LEN - 4'd1);

    // steer the incoming byte into its field
    always_comb begin
        shadow_nxt = shadow;
        case (byte_cnt)
            4'd0:    shadow_nxt.mode      = rx_byte;
            4'd1:    shadow_nxt.intensity = rx_byte;
            4'd2:    shadow_nxt.red       = rx_byte;
            4'd3:    shadow_nxt.green     = rx_byte;
            4'd4:    shadow_nxt.blue      = rx_byte;
            4'd5:    shadow_nxt.white     = rx_byte;
            default: shadow_nxt = shadow;
        endcase
    end

    always_ff @(posedge clk) begin
        if (take_byte) begin
            shadow <= shadow_nxt;
        end
    end

    // counter and commit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt   <= '0;
            cfg        <= '0;
            cfg_update <= 1'b0;
        end else begin
            cfg_update <= 1'b0;
            if (cs_idle) begin
                // short frame never reaches the commit
                byte_cnt <= '0;
            end else if (take_byte) begin
                // holds at frame length until deselect
                byte_cnt <= byte_cnt + 4'd1;
            end
            if (last_byte) begin
                // whole frame lands in one edge
                cfg        <= shadow_nxt;
                cfg_update <= 1'b1;
            end
        end
    end

endmodule

/* hdl/color_scaler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour scaler, committed frame to four PWM duties
// one shift-add multiplier walks r, g, b, w in scaled mode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module color_scaler (
    input  logic                clk,
    input  logic                rst_n,
    input  rgbw_pkg::rgbw_cfg_t cfg,
    input  logic                cfg_update,
    output rgbw_pkg::duty_t     duty,
    output logic                duty_update
);

    import rgbw_pkg::*;

    logic        busy;
    // channel 0..3 is r, g, b, w
    logic [1:0]  ch;
    // step 0 loads, steps 1..8 add and shift
    logic [3:0]  step;
    logic [15:0] acc;
    logic [15:0] acc_nxt;
    logic [7:0]  mcand;
    logic [7:0]  mplier;
    logic [7:0]  colour;
    // finished upper bytes, oldest channel on top
    logic [23:0] partial;

    always_comb begin
        case (ch)
            2'd0:    colour = cfg.red;
            2'd1:    colour = cfg.green;
            2'd2:    colour = cfg.blue;
            default: colour = cfg.white;
        endcase
    end

    // multiplier MSB first, accumulator doubles each step
    assign acc_nxt = {acc[14:0], 1'b0} + (mplier[7] ? {8'd0, mcand} : 16'd0);

    // sequencing and result write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            ch          <= '0;
            step        <= '0;
            duty        <= '0;
            duty_update <= 1'b0;
        end else begin
            duty_update <= 1'b0;
            if (cfg_update) begin
                // newest frame always restarts the sequence
                ch   <= '0;
                step <= '0;
                case (cfg.mode)
                    MODE_DIRECT: begin
                        busy        <= 1'b0;
                        duty        <= {cfg.red, cfg.green, cfg.blue, cfg.white};
                        duty_update <= 1'b1;
                    end
                    MODE_SCALED: begin
                        busy <= 1'b1;
                    end
                    default: begin
                        // off
                        busy        <= 1'b0;
                        duty        <= '0;
                        duty_update <= 1'b1;
                    end
                endcase
            end else if (busy) begin
                if (step == 4'd8) begin
                    step <= '0;
                    ch   <= ch + 2'd1;
                    if (ch == 2'd3) begin
                        // white is the last product, all four go out together
                        busy        <= 1'b0;
                        duty        <= {partial, acc_nxt[15:8]};
                        duty_update <= 1'b1;
                    end
                end else begin
                    step <= step + 4'd1;
                end
            end
        end
    end

    // multiplier data path
    always_ff @(posedge clk) begin
        if (busy) begin
            if (step == 4'd0) begin
                acc    <= '0;
                mcand  <= colour;
                mplier <= cfg.intensity;
            end else begin
                acc    <= acc_nxt;
                mplier <= {mplier[6:0], 1'b0};
            end
            if (step == 4'd8) begin
                // keep only the upper byte of the product
                partial <= {partial[15:0], acc_nxt[15:8]};
            end
        end
    end

endmodule

/* hdl/pwm_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-channel PWM generator with prescaler
// new duties take effect at the next period start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "rgbw_macros.svh"

module pwm_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  rgbw_pkg::duty_t     duty,
    input  logic                duty_update,
    output rgbw_pkg::led_pins_t led
);

    import rgbw_pkg::*;

    localparam int DIV = `RGBW_PWM_DIV;
    localparam int PW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [PW-1:0] presc;
    logic          tick;
    // period counter 0..254
    logic [7:0]    cnt;
    // latest duty waiting for the period start
    duty_t         pending;
    // duties used by the comparators this period
    duty_t         shadow;

    assign tick = (presc == PW'(DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc   <= '0;
            cnt     <= '0;
            pending <= '0;
            shadow  <= '0;
            led     <= '0;
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
            if (duty_update) begin
                pending <= duty;
            end
            if (tick) begin
                if (cnt == 8'd254) begin
                    cnt    <= '0;
                    shadow <= pending;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end
            // high while below duty, 255 never drops
            led.r <= (cnt < shadow.r);
            led.g <= (cnt < shadow.g);
            led.b <= (cnt < shadow.b);
            led.w <= (cnt < shadow.w);
        end
    end

endmodule

/* hdl/rgbw_controller_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the SPI-driven RGBW LED dimmer
// SPI receiver, frame registers, colour scaler and PWM in one clk domain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module rgbw_controller_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sck,
    input  logic                cs_n,
    input  logic                mosi,
    output rgbw_pkg::led_pins_t led,
    output logic [3:0]          byte_cnt
);

    import rgbw_pkg::*;

    // receiver to frame registers
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       cs_idle;
    // frame registers to scaler
    rgbw_cfg_t  cfg;
    logic       cfg_update;
    // scaler to PWM
    duty_t      duty;
    logic       duty_update;

    spi_byte_rx u_spi_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cs_idle  (cs_idle)
    );

    rgbw_frame_regs u_frame_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .cs_idle    (cs_idle),
        .cfg        (cfg),
        .cfg_update (cfg_update),
        .byte_cnt   (byte_cnt)
    );

    color_scaler u_scaler (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .cfg_update  (cfg_update),
        .duty        (duty),
        .duty_update (duty_update)
    );

    pwm_gen u_pwm (
        .clk         (clk),
        .rst_n       (rst_n),
        .duty        (duty),
        .duty_update (duty_update),
        .led         (led)
    );

endmodule

/* testbench/rgbw_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the RGBW dimmer internals
// bound into the top level
// fail_cnt counts fired assertions for the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "rgbw_macros.svh"

module rgbw_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                rx_valid,
    input logic                cfg_update,
    input logic [3:0]          byte_cnt,
    input rgbw_pkg::led_pins_t led,
    input rgbw_pkg::duty_t     pwm_shadow
);

    // fired assertions so far
    int fail_cnt = 0;

    // byte strobe is a single pulse
    a_rx_single: assert property (
        @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("rx_valid stayed high for two cycles");
    end

    // commit only right after the sixth byte strobe
    a_cfg_after_rx: assert property (
        @(posedge clk) disable iff (!rst_n) cfg_update |-> $past(rx_valid)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("cfg_update without a byte strobe the cycle before");
    end

    // zero duties in the comparators mean dark pins
    a_dark_at_zero: assert property (
        @(posedge clk) disable iff (!rst_n) (pwm_shadow == '0) |=> (led == '0)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("led pin high while the active duty is zero");
    end

    // reset clears the pins and the byte count
    a_reset_dark: assert property (
        @(posedge clk) !rst_n |=> (led == '0 && byte_cnt == 4'd0)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("led or byte_cnt not cleared by reset");
    end

    a_cnt_limit: assert property (
        @(posedge clk) disable iff (!rst_n) byte_cnt <= 4'(`RGBW_FRAME_BYTES)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("byte_cnt past the frame length");
    end

endmodule

bind rgbw_controller_top rgbw_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_valid   (rx_valid),
    .cfg_update (cfg_update),
    .byte_cnt   (byte_cnt),
    .led        (led),
    .pwm_shadow (u_pwm.shadow)
);

/* testbench/rgbw_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the SPI-driven RGBW dimmer top level
// sends frames over SPI, measures PWM high time on every pin
// build and run through the Makefile
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "rgbw_macros.svh"

module rgbw_tb;

    import rgbw_pkg::*;

    localparam int CLK_NS     = 8;
    localparam int SCK_HALF   = 4;
    localparam int CS_SETTLE  = 6;
    localparam int FRAME_LEN  = `RGBW_FRAME_BYTES;
    localparam int MAX_BYTES  = 8;
    localparam int PERIOD_CYC = 255 * `RGBW_PWM_DIV;
    // longest frame on the wire plus select setup and release
    localparam int FRAME_CYC  = MAX_BYTES * 16 * SCK_HALF + 4 * SCK_HALF + CS_SETTLE;
    // reset check takes one frame slot
    localparam int N_FRAMES   = 14;
    localparam int WATCHDOG_CYC = N_FRAMES * (3 * PERIOD_CYC + FRAME_CYC) + 2000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       sck;
    logic       cs_n;
    logic       mosi;
    led_pins_t  led;
    logic [3:0] byte_cnt;

    // next frame in wire order
    logic [7:0] frame_q [$];
    // duties of the last complete frame
    duty_t      exp_duty;

    rgbw_controller_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .led      (led),
        .byte_cnt (byte_cnt)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped on first failure");
    endtask

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        assert (actual == expected)
        else abort_run($sformatf("[ERROR] %s %s expected %0d actual %0d",
                                 test, what, expected, actual));
    endtask

    // direct passes the colour byte
    // scaled keeps the upper product byte and other modes are off
    function automatic logic [7:0] duty_rule(input logic [7:0] mode,
                                             input logic [7:0] intensity,
                                             input logic [7:0] colour);
        logic [15:0] prod;
        prod = 16'(colour) * 16'(intensity);
        if (mode == 8'd0) begin
            return colour;
        end else if (mode == 8'd1) begin
            return prod[15:8];
        end
        return 8'd0;
    endfunction

    task automatic expect_frame();
        exp_duty.r = duty_rule(frame_q[0], frame_q[1], frame_q[2]);
        exp_duty.g = duty_rule(frame_q[0], frame_q[1], frame_q[3]);
        exp_duty.b = duty_rule(frame_q[0], frame_q[1], frame_q[4]);
        exp_duty.w = duty_rule(frame_q[0], frame_q[1], frame_q[5]);
    endtask

    task automatic fill_random();
        frame_q.delete();
        repeat (MAX_BYTES) begin
            frame_q.push_back(8'($urandom));
        end
    endtask

    // mode 0 timing with data set up while sck low and MSB first
    task automatic spi_send_byte(input logic [7:0] b);
        logic [7:0] sh;
        sh = b;
        repeat (8) begin
            sck  <= 1'b0;
            mosi <= sh[7];
            sh   = sh << 1;
            repeat (SCK_HALF) @(posedge clk);
            sck <= 1'b1;
            repeat (SCK_HALF) @(posedge clk);
        end
    endtask

    task automatic send_frame(input string test, input int n_bytes);
        int exp_cnt;
        // counter holds at the frame length
        exp_cnt = (n_bytes < FRAME_LEN) ? n_bytes : FRAME_LEN;
        @(posedge clk);
        cs_n <= 1'b0;
        repeat (SCK_HALF) @(posedge clk);
        for (int n = 0; n < n_bytes; n++) begin
            spi_send_byte(frame_q[n]);
        end
        sck <= 1'b0;
        repeat (SCK_HALF) @(posedge clk);
        @(negedge clk);
        check_value(test, "byte_cnt in frame", exp_cnt, int'(byte_cnt));
        @(posedge clk);
        cs_n <= 1'b1;
        repeat (CS_SETTLE) @(posedge clk);
        @(negedge clk);
        check_value(test, "byte_cnt after cs_n", 0, int'(byte_cnt));
    endtask

    task automatic measure_duties(input string test);
        int hi_r;
        int hi_g;
        int hi_b;
        int hi_w;
        hi_r = 0;
        hi_g = 0;
        hi_b = 0;
        hi_w = 0;
        // scaler done and a fresh period loaded well before this ends
        repeat (2 * PERIOD_CYC) @(posedge clk);
        repeat (PERIOD_CYC) begin
            @(negedge clk);
            if (led.r) hi_r++;
            if (led.g) hi_g++;
            if (led.b) hi_b++;
            if (led.w) hi_w++;
        end
        check_value(test, "led.r high cycles", int'(exp_duty.r) * `RGBW_PWM_DIV, hi_r);
        check_value(test, "led.g high cycles", int'(exp_duty.g) * `RGBW_PWM_DIV, hi_g);
        check_value(test, "led.b high cycles", int'(exp_duty.b) * `RGBW_PWM_DIV, hi_b);
        check_value(test, "led.w high cycles", int'(exp_duty.w) * `RGBW_PWM_DIV, hi_w);
    endtask

    // stop at the first fired bound assertion
    always @(negedge clk) begin
        if (u_dut.u_asserts.fail_cnt != 0) begin
            abort_run("a bound assertion on the DUT internals fired");
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(32'ha114_4657));
        rst_n    = 1'b0;
        sck      = 1'b0;
        cs_n     = 1'b1;
        mosi     = 1'b0;
        exp_duty = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset", "byte_cnt", 0, int'(byte_cnt));
        measure_duties("reset");

        // rails in the first two frames
        for (int f = 0; f < 3; f++) begin
            fill_random();
            frame_q[0] = 8'd0;
            if (f == 0) begin
                frame_q[2] = 8'd0;
                frame_q[5] = 8'd255;
            end else if (f == 1) begin
                frame_q[3] = 8'd255;
                frame_q[4] = 8'd0;
            end
            expect_frame();
            send_frame("direct", FRAME_LEN);
            measure_duties("direct");
        end

        for (int f = 0; f < 3; f++) begin
            fill_random();
            frame_q[0] = 8'd1;
            if (f == 0) begin
                // full intensity and full red
                frame_q[1] = 8'd255;
                frame_q[2] = 8'd255;
            end
            expect_frame();
            send_frame("scaled", FRAME_LEN);
            measure_duties("scaled");
        end

        for (int f = 0; f < 2; f++) begin
            fill_random();
            frame_q[0] = (f == 0) ? 8'hff : 8'($urandom_range(254, 2));
            expect_frame();
            send_frame("off", FRAME_LEN);
            measure_duties("off");
        end

        // known duties then a cut frame that must not touch them
        fill_random();
        frame_q[0] = 8'd0;
        expect_frame();
        send_frame("abort base", FRAME_LEN);
        measure_duties("abort base");
        fill_random();
        frame_q[0] = 8'd0;
        send_frame("abort cut", 4);
        measure_duties("abort cut");

        // bytes seven and eight fall away
        fill_random();
        frame_q[0] = 8'd0;
        expect_frame();
        send_frame("overlong", MAX_BYTES);
        measure_duties("overlong");

        // second scaled frame right behind the first wins
        fill_random();
        frame_q[0] = 8'd1;
        send_frame("back to back", FRAME_LEN);
        fill_random();
        frame_q[0] = 8'd1;
        expect_frame();
        send_frame("back to back", FRAME_LEN);
        measure_duties("back to back");

        if (u_dut.u_asserts.fail_cnt == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("bound assertion failures were recorded");
        end
    end

endmodule

/* rgbw_controller_top.f */
+incdir+hdl
hdl/rgbw_pkg.sv
hdl/spi_byte_rx.sv
hdl/rgbw_frame_regs.sv
hdl/color_scaler.sv
hdl/pwm_gen.sv
hdl/rgbw_controller_top.sv
testbench/rgbw_asserts.sv
testbench/rgbw_tb.sv

/* Makefile */
# Verilator build and run for the RGBW dimmer testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := rgbw_tb
FLIST     := rgbw_controller_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+100
FAIL_MSG  := === FAIL ===

SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF -- "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
